// File: rtl/obi_bus_pkg.sv
// --------------------
// OBI bus package
// Bus widths and the request and response structs of every link
// --------------------

package obi_bus_pkg;

  // --------------------
  // Bus widths
  localparam int unsigned OBI_ADDR_WIDTH = 32;
  localparam int unsigned OBI_DATA_WIDTH = 32;
  localparam int unsigned OBI_BE_WIDTH   = OBI_DATA_WIDTH / 8;

  // --------------------
  // Request channel, driven by a master
  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [OBI_BE_WIDTH-1:0]   be;
    logic [OBI_ADDR_WIDTH-1:0] addr;
    logic [OBI_DATA_WIDTH-1:0] wdata;
  } obi_req_t;

  // --------------------
  // Response channel, driven by the slave side
  // gnt closes the address phase, rvalid the response phase
  typedef struct packed {
    logic                      gnt;
    logic                      rvalid;
    logic [OBI_DATA_WIDTH-1:0] rdata;
  } obi_resp_t;

endpackage

// File: rtl/ext_mem_pkg.sv
// --------------------
// External memory package
// Sizes, limits and state encoding of the slow memory path
// --------------------

package ext_mem_pkg;

  // Bus masters sharing the memory
  localparam int unsigned NUM_MASTERS = 2;

  // --------------------
  // Memory geometry
  localparam int unsigned MEM_WORDS      = 128;
  // Word index comes from byte address bits 8..2
  localparam int unsigned MEM_ADDR_WIDTH = $clog2(MEM_WORDS);

  // --------------------
  // Flow control limits
  localparam int unsigned MAX_OUTSTANDING = 4;
  localparam int unsigned REQ_FIFO_DEPTH  = 2;
  localparam int unsigned MEM_MAX_LATENCY = 8;

  // --------------------
  // Power switch model
  localparam int unsigned SWITCH_ACK_LATENCY = 15;
  localparam int unsigned NUM_PWR_DOMAINS    = 2;

  // Slow memory FSM
  typedef enum logic {
    MEM_IDLE,
    MEM_BUSY
  } mem_state_e;

endpackage

// File: rtl/obi_master_arbiter.sv
// --------------------
// OBI N-to-1 arbiter
// Round-robin grant, responses steered back in acceptance order
// --------------------

module obi_master_arbiter (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  obi_bus_pkg::obi_req_t  [ext_mem_pkg::NUM_MASTERS-1:0] master_req_i,
  output obi_bus_pkg::obi_resp_t [ext_mem_pkg::NUM_MASTERS-1:0] master_resp_o,
  output obi_bus_pkg::obi_req_t                                 slave_req_o,
  input  obi_bus_pkg::obi_resp_t                                slave_resp_i
);

  import obi_bus_pkg::*;
  import ext_mem_pkg::*;

  typedef logic [$clog2(NUM_MASTERS)-1:0]       master_idx_t;
  typedef logic [$clog2(MAX_OUTSTANDING)-1:0]   oq_ptr_t;
  typedef logic [$clog2(MAX_OUTSTANDING+1)-1:0] oq_cnt_t;

  master_idx_t rr_ptr_q;
  master_idx_t sel_idx;
  logic        any_req;
  logic        accept;

  // Order queue of granted master indices
  master_idx_t oq_q [MAX_OUTSTANDING];
  oq_ptr_t     oq_wr_ptr_q;
  oq_ptr_t     oq_rd_ptr_q;
  oq_cnt_t     oq_cnt_q;
  logic        oq_full;
  master_idx_t oq_head;

  // --------------------
  // Selection, starting at the round-robin pointer
  always_comb begin
    master_idx_t cand;
    any_req = 1'b0;
    sel_idx = rr_ptr_q;
    for (int unsigned off = 0; off < NUM_MASTERS; off++) begin
      cand = master_idx_t'((rr_ptr_q + off) % NUM_MASTERS);
      if (!any_req && master_req_i[cand].req) begin
        any_req = 1'b1;
        sel_idx = cand;
      end
    end
  end

  assign oq_full = (oq_cnt_q == oq_cnt_t'(MAX_OUTSTANDING));
  assign oq_head = oq_q[oq_rd_ptr_q];

  // Hold req low while the order queue cannot take another entry
  always_comb begin
    slave_req_o     = master_req_i[sel_idx];
    slave_req_o.req = any_req && !oq_full;
  end

  assign accept = slave_req_o.req && slave_resp_i.gnt;

  // --------------------
  // Response steering
  always_comb begin
    master_resp_o = '0;
    if (accept) begin
      master_resp_o[sel_idx].gnt = 1'b1;
    end
    if (slave_resp_i.rvalid) begin
      master_resp_o[oq_head].rvalid = 1'b1;
      master_resp_o[oq_head].rdata  = slave_resp_i.rdata;
    end
  end

  function automatic oq_ptr_t oq_ptr_next(oq_ptr_t ptr);
    if (ptr == oq_ptr_t'(MAX_OUTSTANDING - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // --------------------
  // Pointers and counters
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q    <= '0;
      oq_wr_ptr_q <= '0;
      oq_rd_ptr_q <= '0;
      oq_cnt_q    <= '0;
    end else begin
      if (accept) begin
        // Other master gets priority next
        rr_ptr_q    <= master_idx_t'((sel_idx + 1) % NUM_MASTERS);
        oq_wr_ptr_q <= oq_ptr_next(oq_wr_ptr_q);
      end
      if (slave_resp_i.rvalid) begin
        oq_rd_ptr_q <= oq_ptr_next(oq_rd_ptr_q);
      end
      case ({accept, slave_resp_i.rvalid})
        2'b10:   oq_cnt_q <= oq_cnt_q + 1'b1;
        2'b01:   oq_cnt_q <= oq_cnt_q - 1'b1;
        default: oq_cnt_q <= oq_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      oq_q[oq_wr_ptr_q] <= sel_idx;
    end
  end

endmodule

// File: rtl/obi_req_fifo.sv
// --------------------
// OBI request FIFO
// Buffers granted requests, responses pass straight through
// --------------------

module obi_req_fifo (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  obi_bus_pkg::obi_req_t  producer_req_i,
  output obi_bus_pkg::obi_resp_t producer_resp_o,
  output obi_bus_pkg::obi_req_t  consumer_req_o,
  input  obi_bus_pkg::obi_resp_t consumer_resp_i
);

  import obi_bus_pkg::*;
  import ext_mem_pkg::*;

  typedef logic [$clog2(REQ_FIFO_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(REQ_FIFO_DEPTH+1)-1:0] cnt_t;

  obi_req_t entry_q [REQ_FIFO_DEPTH];
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  cnt_t     cnt_q;
  logic     full;
  logic     empty;
  logic     push;
  logic     pop;

  assign full  = (cnt_q == cnt_t'(REQ_FIFO_DEPTH));
  assign empty = (cnt_q == '0);

  // --------------------
  // Producer side
  always_comb begin
    producer_resp_o        = '0;
    producer_resp_o.gnt    = !full;
    producer_resp_o.rvalid = consumer_resp_i.rvalid;
    producer_resp_o.rdata  = consumer_resp_i.rdata;
  end

  assign push = producer_req_i.req && !full;

  // --------------------
  // Consumer side, oldest entry first
  always_comb begin
    consumer_req_o     = entry_q[rd_ptr_q];
    consumer_req_o.req = !empty;
  end

  assign pop = consumer_req_o.req && consumer_resp_i.gnt;

  function automatic ptr_t ptr_next(ptr_t ptr);
    if (ptr == ptr_t'(REQ_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_ptr_q] <= producer_req_i;
    end
  end

endmodule

// File: rtl/obi_slow_memory.sv
// --------------------
// Slow OBI memory
// 128 words, byte enables, LFSR-driven response latency
// --------------------

module obi_slow_memory (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  obi_bus_pkg::obi_req_t  mem_req_i,
  output obi_bus_pkg::obi_resp_t mem_resp_o
);

  import obi_bus_pkg::*;
  import ext_mem_pkg::*;

  typedef logic [$clog2(MEM_MAX_LATENCY+1)-1:0] wait_cnt_t;

  logic [OBI_DATA_WIDTH-1:0] mem_q [MEM_WORDS];
  logic [OBI_DATA_WIDTH-1:0] rdata_q;
  logic [MEM_ADDR_WIDTH-1:0] word_idx;
  mem_state_e                state_q;
  wait_cnt_t                 wait_cnt_q;
  wait_cnt_t                 latency;
  logic [7:0]                lfsr_q;
  logic                      lfsr_fb;
  logic                      accept;

  // Upper address bits alias onto the same words
  assign word_idx = mem_req_i.addr[MEM_ADDR_WIDTH+1:2];
  assign accept   = mem_req_i.req && (state_q == MEM_IDLE);

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  // 1 to MEM_MAX_LATENCY cycles
  assign latency = wait_cnt_t'(lfsr_q % MEM_MAX_LATENCY) + wait_cnt_t'(1);

  // --------------------
  // FSM and latency counter
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= MEM_IDLE;
      wait_cnt_q <= '0;
      lfsr_q     <= 8'hA5;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      case (state_q)
        MEM_IDLE: begin
          if (accept) begin
            state_q    <= MEM_BUSY;
            wait_cnt_q <= latency;
          end
        end
        MEM_BUSY: begin
          if (wait_cnt_q == wait_cnt_t'(1)) begin
            state_q <= MEM_IDLE;
          end
          wait_cnt_q <= wait_cnt_q - 1'b1;
        end
        default: state_q <= MEM_IDLE;
      endcase
    end
  end

  // --------------------
  // Array access at grant time
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (mem_req_i.we) begin
        for (int b = 0; b < OBI_BE_WIDTH; b++) begin
          if (mem_req_i.be[b]) begin
            mem_q[word_idx][b*8 +: 8] <= mem_req_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  // rvalid in the last wait cycle
  always_comb begin
    mem_resp_o        = '0;
    mem_resp_o.gnt    = accept;
    mem_resp_o.rvalid = (state_q == MEM_BUSY) && (wait_cnt_q == wait_cnt_t'(1));
    mem_resp_o.rdata  = rdata_q;
  end

endmodule

// File: rtl/pwr_switch_ack_delay.sv
// --------------------
// Power switch acknowledge delay
// Switch cells answer each request a fixed number of cycles late
// --------------------

module pwr_switch_ack_delay (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic [ext_mem_pkg::NUM_PWR_DOMAINS-1:0] pwr_switch_n_i,
  output logic [ext_mem_pkg::NUM_PWR_DOMAINS-1:0] pwr_switch_ack_n_o
);

  import ext_mem_pkg::*;

  // One stage per cycle of latency, all domains side by side
  logic [NUM_PWR_DOMAINS-1:0] stage_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Every domain starts switched off
      for (int s = 0; s < SWITCH_ACK_LATENCY; s++) begin
        stage_q[s] <= '1;
      end
    end else begin
      stage_q[0] <= pwr_switch_n_i;
      for (int s = 1; s < SWITCH_ACK_LATENCY; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  assign pwr_switch_ack_n_o = stage_q[SWITCH_ACK_LATENCY-1];

endmodule

// File: rtl/ext_mem_subsystem.sv
// --------------------
// External memory subsystem
// Arbiter, request FIFO, slow memory and switch acknowledge model
// --------------------

module ext_mem_subsystem (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  obi_bus_pkg::obi_req_t  [ext_mem_pkg::NUM_MASTERS-1:0] master_req_i,
  output obi_bus_pkg::obi_resp_t [ext_mem_pkg::NUM_MASTERS-1:0] master_resp_o,
  input  logic [ext_mem_pkg::NUM_PWR_DOMAINS-1:0]               pwr_switch_n_i,
  output logic [ext_mem_pkg::NUM_PWR_DOMAINS-1:0]               pwr_switch_ack_n_o
);

  import obi_bus_pkg::*;

  // Arbiter to FIFO
  obi_req_t  arb_req;
  obi_resp_t arb_resp;

  // FIFO to memory
  obi_req_t  mem_req;
  obi_resp_t mem_resp;

  // --------------------
  // Memory path
  obi_master_arbiter obi_master_arbiter_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .master_req_i (master_req_i),
    .master_resp_o(master_resp_o),
    .slave_req_o  (arb_req),
    .slave_resp_i (arb_resp)
  );

  // Extra latency in front of the memory
  obi_req_fifo obi_req_fifo_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .producer_req_i (arb_req),
    .producer_resp_o(arb_resp),
    .consumer_req_o (mem_req),
    .consumer_resp_i(mem_resp)
  );

  obi_slow_memory obi_slow_memory_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .mem_req_i (mem_req),
    .mem_resp_o(mem_resp)
  );

  // --------------------
  // Power switch model
  pwr_switch_ack_delay pwr_switch_ack_delay_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .pwr_switch_n_i    (pwr_switch_n_i),
    .pwr_switch_ack_n_o(pwr_switch_ack_n_o)
  );

endmodule

// File: sim/tb_clock_gen.sv
// --------------------
// Testbench clock source
// --------------------

module tb_clock_gen #(
  parameter int unsigned PERIOD = 20
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2) clk_o = ~clk_o;
    end
  end

endmodule

// File: sim/tb_ext_mem_subsystem.sv
// --------------------
// Testbench for the external memory subsystem
// Table-driven OBI traffic from two masters, switch acknowledge checks
// --------------------

module tb_ext_mem_subsystem;

  import obi_bus_pkg::*;
  import ext_mem_pkg::*;

  localparam int unsigned MAX_OPS        = 128;
  localparam int unsigned TIMEOUT_CYCLES = 100;
  localparam int unsigned ACK_EDGES      = 15;

  typedef logic [$clog2(NUM_MASTERS)-1:0] master_idx_t;

  // One row of the stimulus table
  typedef struct packed {
    master_idx_t               master;
    logic                      we;
    logic [OBI_ADDR_WIDTH-1:0] addr;
    logic [OBI_BE_WIDTH-1:0]   be;
    logic [OBI_DATA_WIDTH-1:0] wdata;
    logic [OBI_DATA_WIDTH-1:0] exp_rdata;
  } op_t;

  logic                        clk;
  logic                        reset;
  obi_req_t  [NUM_MASTERS-1:0] master_req;
  obi_resp_t [NUM_MASTERS-1:0] master_resp;
  logic [NUM_PWR_DOMAINS-1:0]  pwr_switch_n;
  logic [NUM_PWR_DOMAINS-1:0]  pwr_switch_ack_n;

  op_t                       table_a [MAX_OPS];
  int                        num_ops;
  logic [OBI_DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
  logic [31:0]               rng_state;
  int                        errors;
  int                        checks;
  int                        tests;

  tb_clock_gen #(.PERIOD(20)) tb_clock_gen_i (.clk_o(clk));

  ext_mem_subsystem ext_mem_subsystem_i (
    .clk_i             (clk),
    .reset_i           (reset),
    .master_req_i      (master_req),
    .master_resp_o     (master_resp),
    .pwr_switch_n_i    (pwr_switch_n),
    .pwr_switch_ack_n_o(pwr_switch_ack_n)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic add_op(input int m, input logic we, input logic [31:0] addr,
                        input logic [3:0] be, input logic [31:0] wdata);
    op_t op;
    op.master        = master_idx_t'(m);
    op.we            = we;
    op.addr          = addr;
    op.be            = be;
    op.wdata         = wdata;
    op.exp_rdata     = '0;
    table_a[num_ops] = op;
    num_ops++;
  endtask

  // --------------------
  // Reference memory updated in acceptance order
  task automatic accept_op(input int idx);
    logic [6:0] w;
    w = table_a[idx].addr[8:2];
    if (table_a[idx].we) begin
      for (int b = 0; b < 4; b++) begin
        if (table_a[idx].be[b]) begin
          ref_mem[w][b*8 +: 8] = table_a[idx].wdata[b*8 +: 8];
        end
      end
    end else begin
      table_a[idx].exp_rdata = ref_mem[w];
    end
  endtask

  task automatic check_response(input int m, input int idx);
    if (!table_a[idx].we) begin
      checks++;
      assert (master_resp[m].rdata === table_a[idx].exp_rdata) else begin
        $display("FAILED at %0t: master_resp_o[%0d].rdata expected %h actual %h",
                 $time, m, table_a[idx].exp_rdata, master_resp[m].rdata);
        errors++;
      end
    end
  endtask

  // --------------------
  // Applies table rows first to last-1 with both masters running in parallel
  task automatic run_ops(input string name, input int first, input int last);
    int   list    [NUM_MASTERS][MAX_OPS];
    int   cnt     [NUM_MASTERS];
    int   issued  [NUM_MASTERS];
    int   retired [NUM_MASTERS];
    int   stall   [NUM_MASTERS];
    int   err_before;
    int   idx;
    logic busy;
    logic timed_out;
    err_before = errors;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      cnt[m]     = 0;
      issued[m]  = 0;
      retired[m] = 0;
      stall[m]   = 0;
    end
    for (int i = first; i < last; i++) begin
      idx = table_a[i].master;
      list[idx][cnt[idx]] = i;
      cnt[idx]++;
    end
    busy      = 1'b1;
    timed_out = 1'b0;
    while (busy && !timed_out) begin
      @(negedge clk);
      // Head of each master's list stays on the bus until granted
      for (int m = 0; m < NUM_MASTERS; m++) begin
        master_req[m] = '0;
        if (issued[m] < cnt[m]) begin
          idx                 = list[m][issued[m]];
          master_req[m].req   = 1'b1;
          master_req[m].we    = table_a[idx].we;
          master_req[m].be    = table_a[idx].be;
          master_req[m].addr  = table_a[idx].addr;
          master_req[m].wdata = table_a[idx].wdata;
        end
      end
      #1;
      busy = 1'b0;
      for (int m = 0; m < NUM_MASTERS; m++) begin
        stall[m]++;
        if (master_resp[m].rvalid) begin
          stall[m] = 0;
          assert (retired[m] < issued[m]) else begin
            $display("ERROR at %0t: master %0d got rvalid with no request outstanding",
                     $time, m);
            errors++;
          end
          if (retired[m] < issued[m]) begin
            check_response(m, list[m][retired[m]]);
            retired[m]++;
          end
        end
        if (master_req[m].req && master_resp[m].gnt) begin
          stall[m] = 0;
          accept_op(list[m][issued[m]]);
          issued[m]++;
        end
        if (retired[m] < cnt[m]) begin
          busy = 1'b1;
          if (stall[m] >= TIMEOUT_CYCLES) begin
            $display("ERROR: master %0d saw no gnt or rvalid for %0d cycles in test %s",
                     m, TIMEOUT_CYCLES, name);
            errors++;
            timed_out = 1'b1;
          end
        end
      end
    end
    master_req = '0;
    tests++;
    $display("test %0d %s: %0d ops, %0d errors", tests, name, last - first,
             errors - err_before);
  endtask

  // --------------------
  // Domain 0 switches on while domain 1 stays off
  task automatic switch_ack_test();
    logic [NUM_PWR_DOMAINS-1:0] exp;
    int                         err_before;
    err_before = errors;
    @(negedge clk);
    pwr_switch_n[0] = 1'b0;
    for (int n_edge = 1; n_edge <= ACK_EDGES; n_edge++) begin
      @(negedge clk);
      exp = {1'b1, (n_edge < ACK_EDGES)};
      checks++;
      assert (pwr_switch_ack_n === exp) else begin
        $display("FAILED at %0t: pwr_switch_ack_n_o expected %b actual %b",
                 $time, exp, pwr_switch_ack_n);
        errors++;
      end
    end
    tests++;
    $display("test %0d switch acknowledge: %0d errors", tests, errors - err_before);
  endtask

  initial begin
    int          first;
    logic [31:0] r;
    logic [31:0] a;
    rng_state    = 32'd62;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    num_ops      = 0;
    reset        = 1'b1;
    master_req   = '0;
    pwr_switch_n = '1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    checks++;
    assert (master_resp === '0) else begin
      $display("FAILED at %0t: master_resp_o expected 0 actual %h",
               $time, master_resp);
      errors++;
    end
    checks++;
    assert (pwr_switch_ack_n === '1) else begin
      $display("FAILED at %0t: pwr_switch_ack_n_o expected %b actual %b",
               $time, {NUM_PWR_DOMAINS{1'b1}}, pwr_switch_ack_n);
      errors++;
    end

    first = num_ops;
    add_op(0, 1'b1, 32'h0000_0010, 4'hF, rand32());
    add_op(0, 1'b0, 32'h0000_0010, 4'hF, 32'h0);
    run_ops("write then read", first, num_ops);

    first = num_ops;
    add_op(0, 1'b1, 32'h0000_0020, 4'hF, rand32());
    add_op(0, 1'b1, 32'h0000_0020, 4'b0101, rand32());
    add_op(0, 1'b0, 32'h0000_0020, 4'hF, 32'h0);
    run_ops("byte enables", first, num_ops);

    // 512 bytes up lands on the same word
    first = num_ops;
    add_op(1, 1'b1, 32'h0000_0040, 4'hF, rand32());
    add_op(1, 1'b0, 32'h0000_0240, 4'hF, 32'h0);
    run_ops("address aliasing", first, num_ops);

    first = num_ops;
    for (int k = 0; k < 2; k++) begin
      add_op(0, 1'b1, 32'h0000_0100 + 4 * k, 4'hF, rand32());
      add_op(1, 1'b1, 32'h0000_0180 + 4 * k, 4'hF, rand32());
    end
    for (int k = 0; k < 2; k++) begin
      add_op(0, 1'b0, 32'h0000_0100 + 4 * k, 4'hF, 32'h0);
      add_op(1, 1'b0, 32'h0000_0180 + 4 * k, 4'hF, 32'h0);
    end
    run_ops("two masters", first, num_ops);

    // Known contents for the words the burst uses
    first = num_ops;
    for (int k = 0; k < 16; k++) begin
      add_op(0, 1'b1, 4 * k, 4'hF, rand32());
    end
    run_ops("burst preload", first, num_ops);

    first = num_ops;
    for (int k = 0; k < 40; k++) begin
      r = rand32();
      a = rand32();
      add_op(r[1], r[0], {a[31:9], 3'b000, r[5:2], 2'b00}, r[9:6], rand32());
    end
    run_ops("back-pressure burst", first, num_ops);

    switch_ack_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: files.f
rtl/obi_bus_pkg.sv
rtl/ext_mem_pkg.sv
rtl/obi_master_arbiter.sv
rtl/obi_req_fifo.sv
rtl/obi_slow_memory.sv
rtl/pwr_switch_ack_delay.sv
rtl/ext_mem_subsystem.sv
sim/tb_clock_gen.sv
sim/tb_ext_mem_subsystem.sv
